//--- src/dot_consts.svh
`ifndef DOT_CONSTS_SVH
`define DOT_CONSTS_SVH

// operand width of each vector element.
`define DATA_W 16

// accumulator width, leaving guard bits above the 32-bit product
// so that 255 full-scale products cannot overflow.
`define ACC_W 40

// vector length width, lengths run from 0 to 255.
`define LEN_W 8

`endif

//--- src/dot_pkg.sv
`default_nettype none

`include "dot_consts.svh"

package dot_pkg;

  // one element of each input vector, sampled together.
  typedef struct packed {
    logic signed [`DATA_W-1:0] x;
    logic signed [`DATA_W-1:0] y;
  } operand_pair_t;

  // running sum and final result of the dot product.
  typedef logic signed [`ACC_W-1:0] acc_t;

  // the engine is idle, taking samples, letting the last product settle
  // into the accumulator, or presenting the finished sum.
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2,
    DONE  = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/booth_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "dot_consts.svh"

module booth_multiplier (
  input  logic signed [`DATA_W-1:0]   x,
  input  logic signed [`DATA_W-1:0]   y,
  output logic signed [2*`DATA_W-1:0] product
);

  localparam int PW   = 2 * `DATA_W;
  localparam int NDIG = `DATA_W / 2;

  // one radix-4 digit selects 0, +x, +2x, -2x or -x.
  function automatic logic signed [PW-1:0] booth_pp(
    input logic [2:0]          trip,
    input logic signed [PW-1:0] xe
  );
    case (trip)
      3'b001, 3'b010: booth_pp = xe;
      3'b011:         booth_pp = xe <<< 1;
      3'b100:         booth_pp = -(xe <<< 1);
      3'b101, 3'b110: booth_pp = -xe;
      default:        booth_pp = '0;
    endcase
  endfunction

  logic signed [PW-1:0]    x_ext;
  logic        [`DATA_W:0] y_ext;
  logic signed [PW-1:0]    pp [NDIG];

  logic signed [PW-1:0] sum01;
  logic signed [PW-1:0] sum23;
  logic signed [PW-1:0] sum45;
  logic signed [PW-1:0] sum67;

  // x is sign-extended up front so that 2x and -2x stay exact,
  // even for the most negative operand.
  assign x_ext = PW'(x);

  // the implicit zero below bit 0 starts the overlapping triplets.
  assign y_ext = {y, 1'b0};

  for (genvar i = 0; i < NDIG; i++) begin : g_digit
    assign pp[i] = booth_pp(y_ext[2*i +: 3], x_ext) <<< (2 * i);
  end

  // adder tree, pairs first and then the final sum.
  assign sum01 = pp[0] + pp[1];
  assign sum23 = pp[2] + pp[3];
  assign sum45 = pp[4] + pp[5];
  assign sum67 = pp[6] + pp[7];

  // the top digit carries the sign of y, so the modulo-2^32 sum is the
  // exact signed product.
  assign product = (sum01 + sum23) + (sum45 + sum67);

endmodule

`default_nettype wire

//--- src/sample_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "dot_consts.svh"

module sample_counter (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load,
  input  logic [`LEN_W-1:0] len,
  input  logic              accept,
  output logic              last,
  output logic              empty
);

  logic [`LEN_W-1:0] count_q;

  // count of samples still expected in the current vector.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= len;
    end else if (accept && (count_q != '0)) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign last  = (count_q == `LEN_W'(1));
  assign empty = (count_q == '0);

endmodule

`default_nettype wire

//--- src/dot_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "dot_consts.svh"

module dot_ctrl_fsm
  import dot_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic sample_valid,
  input  logic last,
  input  logic empty,
  output logic load,
  output logic clear,
  output logic accept,
  output logic busy,
  output logic done
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        run;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start) begin
          state_d = RUN;
        end
      end
      // a zero-length vector leaves RUN without taking any sample.
      RUN: begin
        if (empty || (accept && last)) begin
          state_d = DRAIN;
        end
      end
      // the last operand pair sits in the stage and is summed here.
      DRAIN: state_d = DONE;
      DONE:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  assign run = (state_q == RUN);

  // a new vector starts only from IDLE, which drops starts while busy.
  assign load  = (state_q == IDLE) && start;
  assign clear = (state_q == IDLE) && start;

  // never take a sample once the count has run out.
  assign accept = run && sample_valid && !empty;

  assign busy = run || (state_q == DRAIN);
  assign done = (state_q == DONE);

endmodule

`default_nettype wire

//--- src/mac_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "dot_consts.svh"

module mac_datapath
  import dot_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          clear,
  input  logic          accept,
  input  operand_pair_t sample,
  output acc_t          result
);

  operand_pair_t stage_q;
  logic          stage_vld_q;
  acc_t          acc_q;

  logic signed [2*`DATA_W-1:0] product;
  acc_t                        product_ext;

  // operand stage in front of the multiplier.
  always_ff @(posedge clk) begin
    if (accept) begin
      stage_q <= sample;
    end
  end

  booth_multiplier u_mult (
    .x       (stage_q.x),
    .y       (stage_q.y),
    .product (product)
  );

  assign product_ext = {{(`ACC_W - 2*`DATA_W){product[2*`DATA_W-1]}}, product};

  // the accumulator takes the staged product one cycle after accept,
  // while the next pair may already be loading into the stage.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_vld_q <= 1'b0;
      acc_q       <= '0;
    end else if (clear) begin
      stage_vld_q <= 1'b0;
      acc_q       <= '0;
    end else begin
      stage_vld_q <= accept;
      if (stage_vld_q) begin
        acc_q <= acc_q + product_ext;
      end
    end
  end

  assign result = acc_q;

endmodule

`default_nettype wire

//--- src/dot_product_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dot_consts.svh"

module dot_product_top
  import dot_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic [`LEN_W-1:0] len,
  input  logic              sample_valid,
  input  operand_pair_t     sample,
  output logic              busy,
  output logic              done,
  output acc_t              result
);

  logic load;
  logic clear;
  logic accept;
  logic last;
  logic empty;

  dot_ctrl_fsm u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .sample_valid (sample_valid),
    .last         (last),
    .empty        (empty),
    .load         (load),
    .clear        (clear),
    .accept       (accept),
    .busy         (busy),
    .done         (done)
  );

  sample_counter u_count (
    .clk    (clk),
    .rst_n  (rst_n),
    .load   (load),
    .len    (len),
    .accept (accept),
    .last   (last),
    .empty  (empty)
  );

  mac_datapath u_mac (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (clear),
    .accept (accept),
    .sample (sample),
    .result (result)
  );

endmodule

`default_nettype wire

//--- tb/dot_product_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dot_product_properties (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic busy,
  input logic done
);

  int failures = 0;

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
  else begin
    failures++;
    $error("done stayed high for more than one cycle");
  end

  a_busy_done: assert property (@(posedge clk) disable iff (!rst_n) !(busy && done))
  else begin
    failures++;
    $error("busy and done were high together");
  end

  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (!busy && !done))
  else begin
    failures++;
    $error("busy or done was high during reset");
  end

  // after done, busy may only come back through an accepted start.
  a_done_idle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
  else begin
    failures++;
    $error("busy was high right after done");
  end

  a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
    (!busy && !start) |=> !busy)
  else begin
    failures++;
    $error("busy rose without a start");
  end

endmodule

bind dot_product_top dot_product_properties u_props (
  .clk   (clk),
  .rst_n (rst_n),
  .start (start),
  .busy  (busy),
  .done  (done)
);

`default_nettype wire

//--- tb/dot_product_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dot_consts.svh"

module dot_product_tb
  import dot_pkg::*;
();

  localparam int MAX_CYCLES = 4000;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              start;
  logic [`LEN_W-1:0] len;
  logic              sample_valid;
  operand_pair_t     sample;
  logic              busy;
  logic              done;
  acc_t              result;

  logic [31:0] seed = 32'hb113_e816;
  int          errors = 0;
  int          cycles = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          errors_at_start;

  // reference sum of the most recent vector, which result must hold until the next start.
  acc_t        last_result = '0;

  logic signed [`DATA_W-1:0] xs [$];
  logic signed [`DATA_W-1:0] ys [$];

  // most negative and most positive operands, where Booth recoding is hardest.
  logic signed [`DATA_W-1:0] corner_x [5] =
    '{16'sh8000, 16'sh8000, 16'sh7fff, 16'shffff, 16'sh0000};
  logic signed [`DATA_W-1:0] corner_y [5] =
    '{16'sh8000, 16'sh7fff, 16'sh7fff, 16'sh0001, 16'sh8000};

  dot_product_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .len          (len),
    .sample_valid (sample_valid),
    .sample       (sample),
    .busy         (busy),
    .done         (done),
    .result       (result)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, done never arrived", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int total_errors();
    return errors + dut.u_props.failures;
  endfunction

  task automatic check_equal(input string name, input longint got, input longint want);
    assert (got == want)
    else begin
      errors++;
      $error("Mismatch at %0d ns: %s = %0d, expected %0d", $time, name, got, want);
    end
  endtask

  task automatic begin_test();
    errors_at_start = total_errors();
  endtask

  task automatic end_test(input string name);
    if (total_errors() == errors_at_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, total_errors() - errors_at_start);
    end
  endtask

  task automatic random_operands(input int n);
    logic [31:0] r;
    xs.delete();
    ys.delete();
    for (int i = 0; i < n; i++) begin
      r = next_random();
      xs.push_back(r[31:16]);
      r = next_random();
      ys.push_back(r[31:16]);
    end
  endtask

  // junk samples while idle, none of which may reach the accumulator.
  task automatic strobe_idle(input int n);
    repeat (n) begin
      sample_valid = 1'b1;
      sample = operand_pair_t'(next_random());
      @(negedge clk);
    end
    sample_valid = 1'b0;
    @(negedge clk);
    check_equal("result", result, last_result);
  endtask

  // runs one vector from xs and ys, with up to gap_max idle cycles before each sample.
  task automatic run_vector(input int gap_max, input bit restart);
    int   n;
    int   gap;
    int   waited;
    acc_t expected;
    n = xs.size();
    expected = '0;
    start = 1'b1;
    len = `LEN_W'(n);
    @(negedge clk);
    start = 1'b0;
    check_equal("busy", busy, 1);
    for (int i = 0; i < n; i++) begin
      gap = int'(next_random() % 32'(gap_max + 1));
      repeat (gap) begin
        sample_valid = 1'b0;
        sample = operand_pair_t'(next_random());
        @(negedge clk);
      end
      if (restart && (i == n / 2)) begin
        start = 1'b1;
        len = `LEN_W'(n + 3);
      end
      sample_valid = 1'b1;
      sample.x = xs[i];
      sample.y = ys[i];
      expected = expected + acc_t'(xs[i]) * acc_t'(ys[i]);
      @(negedge clk);
      start = 1'b0;
    end
    sample_valid = 1'b0;
    waited = 1;
    while (!done) begin
      @(negedge clk);
      waited++;
    end
    check_equal("done latency", waited, (n == 0) ? 3 : 2);
    check_equal("result", result, expected);
    @(negedge clk);
    check_equal("result after done", result, expected);
    last_result = expected;
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    len = '0;
    sample_valid = 1'b0;
    sample = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    begin_test();
    check_equal("busy", busy, 0);
    check_equal("done", done, 0);
    check_equal("result", result, 0);
    end_test("reset state");

    begin_test();
    for (int i = 0; i < 5; i++) begin
      xs.delete();
      ys.delete();
      xs.push_back(corner_x[i]);
      ys.push_back(corner_y[i]);
      run_vector(0, 1'b0);
    end
    end_test("corner products");

    begin_test();
    for (int i = 0; i < 8; i++) begin
      random_operands(1 + int'(next_random() % 32'd16));
      run_vector(0, 1'b0);
    end
    end_test("back-to-back vectors");

    begin_test();
    for (int i = 0; i < 6; i++) begin
      strobe_idle(3);
      random_operands(1 + int'(next_random() % 32'd16));
      run_vector(3, 1'b0);
    end
    end_test("vectors with gaps");

    begin_test();
    random_operands(10);
    run_vector(1, 1'b1);
    end_test("start while running");

    begin_test();
    xs.delete();
    ys.delete();
    run_vector(0, 1'b0);
    end_test("zero length");

    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+src
src/dot_pkg.sv
src/booth_multiplier.sv
src/sample_counter.sv
src/dot_ctrl_fsm.sv
src/mac_datapath.sv
src/dot_product_top.sv
tb/dot_product_properties.sv
tb/dot_product_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the dot-product testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module dot_product_tb -Mdir obj_dir -o dot_product_sim; then
  echo "build failed"
  exit 1
fi

if ! ./obj_dir/dot_product_sim +verilator+error+limit+1000 > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error status"
  exit 1
fi
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
exit 0
